/* hw/smc_bus_pkg.sv */
/*
 * Wishbone bus widths, register map and register field positions
 * of the stepper-motor controller
 */
package smc_bus_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////
  localparam int BUS_W    = 32;  // Data and address width
  localparam int SEL_W    = 4;   // One enable per byte
  localparam int ADDR_LSB = 2;   // Word aligned registers
  localparam int ADDR_W   = 3;   // Eight register slots

  typedef logic [BUS_W-1:0]  bus_word_t;
  typedef logic [ADDR_W-1:0] reg_addr_t;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////
  localparam reg_addr_t CONFIG_ADDR  = 3'd0;  // Enable, type, mode, duty
  localparam reg_addr_t DIVIDER_ADDR = 3'd2;  // Prescaler divider
  localparam reg_addr_t PERIOD_ADDR  = 3'd3;  // PWM periods per step minus 1
  localparam reg_addr_t STEP_ADDR    = 3'd4;  // Run, direction, free, count

  // Configuration register fields, duty sits in the low byte
  localparam int EN_BIT    = 31;
  localparam int PTYPE_BIT = 30;
  localparam int MODE_BIT  = 29;

  // Step command fields, count sits in the low bits
  localparam int RUN_BIT  = 31;
  localparam int DIR_BIT  = 30;
  localparam int FREE_BIT = 29;

endpackage

/* hw/smc_motor_pkg.sv */
/*
 * Datapath widths, motor enums and the coil-pattern table
 */
package smc_motor_pkg;

  localparam int DIV_W    = 32;  // Prescaler counter
  localparam int PERIOD_W = 32;  // Step timer
  localparam int DUTY_W   = 8;   // PWM resolution
  localparam int STEPS_W  = 24;  // Step countdown

  typedef logic [DIV_W-1:0]    div_t;
  typedef logic [PERIOD_W-1:0] period_t;
  typedef logic [DUTY_W-1:0]   duty_t;
  typedef logic [STEPS_W-1:0]  steps_t;

  typedef logic [2:0] phase_t;  // Half-step position in the table
  typedef logic [3:0] coils_t;  // b2 b1 a2 a1

  typedef enum logic {
    UNIPOLAR,
    BIPOLAR
  } motor_type_e;

  typedef enum logic {
    FULL_STEP,
    HALF_STEP
  } drive_mode_e;

  // Half-step sequence, even entries form the full-step sequence
  localparam coils_t COIL_TABLE [8] = '{
    4'b1001, 4'b0001, 4'b0011, 4'b0010,
    4'b0110, 4'b0100, 4'b1100, 4'b1000
  };

endpackage

/* hw/smc_wb_regs.sv */
/*
 * Wishbone slave register bank: configuration, divider, period and
 * step command registers, with the step countdown
 */
module smc_wb_regs (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              wbs_cyc_i,
  input  logic                              wbs_stb_i,
  input  logic                              wbs_we_i,
  input  smc_bus_pkg::bus_word_t            wbs_adr_i,
  input  smc_bus_pkg::bus_word_t            wbs_dat_i,
  input  logic [smc_bus_pkg::SEL_W-1:0]     wbs_sel_i,
  input  logic                              step_strobe_i,  // One pulse per motor step
  output smc_bus_pkg::bus_word_t            wbs_dat_o,
  output logic                              wbs_ack_o,
  output logic                              controller_en_o,
  output smc_motor_pkg::motor_type_e        motor_type_o,
  output smc_motor_pkg::drive_mode_e        drive_mode_o,
  output smc_motor_pkg::duty_t              duty_o,
  output smc_motor_pkg::div_t               divider_o,
  output smc_motor_pkg::period_t            period_o,
  output logic                              run_o,
  output logic                              direction_o
);

  import smc_bus_pkg::*;
  import smc_motor_pkg::*;

  logic      req;
  logic      step_wr;
  reg_addr_t addr;
  bus_word_t byte_mask;
  bus_word_t wr_mask;
  bus_word_t config_word;
  bus_word_t step_word;
  logic      free;
  steps_t    count;
  steps_t    count_set;
  logic      count_dec;
  logic      count_done;

  // Keep old bits where the mask is clear
  function automatic bus_word_t merge_bits(bus_word_t old_v, bus_word_t new_v, bus_word_t mask);
    return (old_v & ~mask) | (new_v & mask);
  endfunction

  ////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////
  assign req     = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;  // New request only
  assign addr    = wbs_adr_i[ADDR_LSB +: ADDR_W];
  assign step_wr = req && (addr == STEP_ADDR);

  always_comb begin
    for (int b = 0; b < SEL_W; b++) begin
      byte_mask[b*8 +: 8] = {8{wbs_sel_i[b]}};
    end
  end

  assign wr_mask = byte_mask & {BUS_W{wbs_we_i}};

  // Readback images, reserved bits stay 0
  always_comb begin
    config_word            = bus_word_t'(duty_o);
    config_word[EN_BIT]    = controller_en_o;
    config_word[PTYPE_BIT] = (motor_type_o == BIPOLAR);
    config_word[MODE_BIT]  = (drive_mode_o == HALF_STEP);
    step_word              = bus_word_t'(count);
    step_word[RUN_BIT]     = run_o;
    step_word[DIR_BIT]     = direction_o;
    step_word[FREE_BIT]    = free;
  end

  ////////////////////////////////////////////////////////////
  // Step countdown
  ////////////////////////////////////////////////////////////
  assign count_set  = step_wr ? steps_t'(wbs_dat_i & wr_mask) : '0;  // Ones only set bits
  assign count_dec  = run_o && step_strobe_i && (count != '0);
  assign count_done = run_o && step_strobe_i && (count == '0) && !free;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wbs_ack_o       <= 1'b0;
      wbs_dat_o       <= '0;
      controller_en_o <= 1'b0;
      motor_type_o    <= UNIPOLAR;
      drive_mode_o    <= FULL_STEP;
      duty_o          <= '0;
      divider_o       <= '0;
      period_o        <= '0;
      run_o           <= 1'b0;
      direction_o     <= 1'b0;
      free            <= 1'b0;
      count           <= '0;
    end else begin
      wbs_ack_o <= req;  // Single-cycle ack
      if (req) begin
        case (addr)
          CONFIG_ADDR: begin
            wbs_dat_o <= config_word;  // Value before the write
            if (wr_mask[EN_BIT]) controller_en_o <= wbs_dat_i[EN_BIT];
            if (wr_mask[PTYPE_BIT]) motor_type_o <= motor_type_e'(wbs_dat_i[PTYPE_BIT]);
            if (wr_mask[MODE_BIT]) drive_mode_o <= drive_mode_e'(wbs_dat_i[MODE_BIT]);
            duty_o <= duty_t'(merge_bits(bus_word_t'(duty_o), wbs_dat_i, wr_mask));
          end
          DIVIDER_ADDR: begin
            wbs_dat_o <= bus_word_t'(divider_o);
            divider_o <= div_t'(merge_bits(bus_word_t'(divider_o), wbs_dat_i, wr_mask));
          end
          PERIOD_ADDR: begin
            wbs_dat_o <= bus_word_t'(period_o);
            period_o  <= period_t'(merge_bits(bus_word_t'(period_o), wbs_dat_i, wr_mask));
          end
          STEP_ADDR: begin
            wbs_dat_o <= step_word;
            if (wr_mask[DIR_BIT]) direction_o <= wbs_dat_i[DIR_BIT];
            if (wr_mask[FREE_BIT]) free <= wbs_dat_i[FREE_BIT];
          end
          default: begin  // Ack without data change
          end
        endcase
      end
      if (step_wr && wr_mask[RUN_BIT]) begin
        run_o <= wbs_dat_i[RUN_BIT];
      end else if (count_done) begin
        run_o <= 1'b0;  // Last step of the command
      end
      count <= (count_dec ? count - steps_t'(1) : count) | count_set;
    end
  end

endmodule

/* hw/tick_prescaler.sv */
/*
 * Clock divider giving a one-clock tick every divider+1 clocks
 */
module tick_prescaler (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       clear_n_i,  // Held at zero when low
  input  smc_motor_pkg::div_t        divider_i,
  output logic                       tick_o
);

  import smc_motor_pkg::*;

  div_t count;

  always_ff @(posedge clk) begin
    if (!rst_n || !clear_n_i) begin
      count  <= '0;
      tick_o <= 1'b0;
    end else if (count >= divider_i) begin
      count  <= '0;  // Also catches a divider lowered mid-count
      tick_o <= 1'b1;
    end else begin
      count  <= count + div_t'(1);
      tick_o <= 1'b0;
    end
  end

endmodule

/* hw/pwm_generator.sv */
/*
 * 8-bit PWM: tick counter, period start strobe and duty compare
 */
module pwm_generator (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       clear_n_i,  // Synchronous clear
  input  logic                       tick_i,
  input  smc_motor_pkg::duty_t       duty_i,
  output logic                       start_o,    // One clock per PWM period
  output logic                       pwm_o
);

  import smc_motor_pkg::*;

  duty_t count;
  logic  wrap;

  assign wrap = tick_i && (count == '1);  // 255 rolls over to 0

  always_ff @(posedge clk) begin
    if (!rst_n || !clear_n_i) begin
      count   <= '0;
      start_o <= 1'b0;
      pwm_o   <= 1'b0;
    end else begin
      if (tick_i) begin
        count <= count + duty_t'(1);
      end
      start_o <= wrap;
      pwm_o   <= (count <= duty_i);  // Duty 255 keeps it high
    end
  end

endmodule

/* hw/motor_sequencer.sv */
/*
 * Step timer, phase counter and coil output stage
 * with full/half step and unipolar/bipolar mapping
 */
module motor_sequencer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       clear_n_i,
  input  smc_motor_pkg::motor_type_e motor_type_i,
  input  smc_motor_pkg::drive_mode_e drive_mode_i,
  input  logic                       direction_i,  // 0 walks the table upward
  input  smc_motor_pkg::period_t     period_i,
  input  logic                       run_i,
  input  logic                       start_i,      // PWM period start
  input  logic                       pwm_i,
  output logic                       step_strobe_o,
  output logic                       motor_a1_o,
  output logic                       motor_a2_o,
  output logic                       motor_b1_o,
  output logic                       motor_b2_o
);

  import smc_motor_pkg::*;

  period_t timer;
  phase_t  phase;
  phase_t  phase_idx;
  coils_t  pattern;
  coils_t  drive;
  logic    step_due;
  logic    pwm_q;

  ////////////////////////////////////////////////////////////
  // Step timer and phase
  ////////////////////////////////////////////////////////////
  assign step_due = run_i && start_i && (timer >= period_i);

  always_ff @(posedge clk) begin
    if (!rst_n || !clear_n_i) begin
      timer         <= '0;
      phase         <= '0;
      step_strobe_o <= 1'b0;
    end else begin
      if (!run_i) begin
        timer <= '0;  // Restart timing on next run
      end else if (start_i) begin
        if (step_due) begin
          timer <= '0;
          phase <= direction_i ? phase - phase_t'(1) : phase + phase_t'(1);
        end else begin
          timer <= timer + period_t'(1);
        end
      end
      step_strobe_o <= step_due;  // Same edge as the phase change
    end
  end

  ////////////////////////////////////////////////////////////
  // Coil output stage
  ////////////////////////////////////////////////////////////
  always_comb begin
    phase_idx = phase & {2'b11, (drive_mode_i == HALF_STEP)};  // Full step uses even entries
    pattern   = COIL_TABLE[phase_idx];
    drive     = pattern;
    if (motor_type_i == BIPOLAR) begin
      drive = {pattern[3], pattern[1], pattern[2], pattern[0]};  // Swap a2 and b1 wires
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || !clear_n_i) begin
      pwm_q      <= 1'b0;
      motor_a1_o <= 1'b0;
      motor_a2_o <= 1'b0;
      motor_b1_o <= 1'b0;
      motor_b2_o <= 1'b0;
    end else begin
      pwm_q      <= pwm_i;  // Second clock of lag comes from the outputs
      motor_a1_o <= drive[0] && pwm_q;
      motor_a2_o <= drive[1] && pwm_q;
      motor_b1_o <= drive[2] && pwm_q;
      motor_b2_o <= drive[3] && pwm_q;
    end
  end

endmodule

/* hw/step_motor_controller.sv */
/*
 * Stepper-motor controller top: register bank, prescaler,
 * PWM generator and motor sequencer
 */
module step_motor_controller (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wbs_cyc_i,
  input  logic                          wbs_stb_i,
  input  smc_bus_pkg::bus_word_t        wbs_adr_i,
  input  logic                          wbs_we_i,
  input  smc_bus_pkg::bus_word_t        wbs_dat_i,
  input  logic [smc_bus_pkg::SEL_W-1:0] wbs_sel_i,
  output smc_bus_pkg::bus_word_t        wbs_dat_o,
  output logic                          wbs_ack_o,
  output logic                          motor_a1_o,
  output logic                          motor_a2_o,
  output logic                          motor_b1_o,
  output logic                          motor_b2_o
);

  import smc_motor_pkg::*;

  logic        controller_en;  // Low holds the datapath in clear
  motor_type_e motor_type;
  drive_mode_e drive_mode;
  duty_t       duty;
  div_t        divider;
  period_t     period;
  logic        run;
  logic        direction;
  logic        step_strobe;
  logic        tick;
  logic        pwm_start;
  logic        pwm;

  ////////////////////////////////////////////////////////////
  // Register bank
  ////////////////////////////////////////////////////////////
  smc_wb_regs wb_regs_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .wbs_cyc_i       (wbs_cyc_i),
    .wbs_stb_i       (wbs_stb_i),
    .wbs_we_i        (wbs_we_i),
    .wbs_adr_i       (wbs_adr_i),
    .wbs_dat_i       (wbs_dat_i),
    .wbs_sel_i       (wbs_sel_i),
    .step_strobe_i   (step_strobe),
    .wbs_dat_o       (wbs_dat_o),
    .wbs_ack_o       (wbs_ack_o),
    .controller_en_o (controller_en),
    .motor_type_o    (motor_type),
    .drive_mode_o    (drive_mode),
    .duty_o          (duty),
    .divider_o       (divider),
    .period_o        (period),
    .run_o           (run),
    .direction_o     (direction)
  );

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////
  tick_prescaler prescaler_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear_n_i (controller_en),
    .divider_i (divider),
    .tick_o    (tick)
  );

  pwm_generator pwm_generator_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear_n_i (controller_en),
    .tick_i    (tick),
    .duty_i    (duty),
    .start_o   (pwm_start),
    .pwm_o     (pwm)
  );

  motor_sequencer motor_sequencer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .clear_n_i     (controller_en),
    .motor_type_i  (motor_type),
    .drive_mode_i  (drive_mode),
    .direction_i   (direction),
    .period_i      (period),
    .run_i         (run),
    .start_i       (pwm_start),
    .pwm_i         (pwm),
    .step_strobe_o (step_strobe),
    .motor_a1_o    (motor_a1_o),
    .motor_a2_o    (motor_a2_o),
    .motor_b1_o    (motor_b1_o),
    .motor_b2_o    (motor_b2_o)
  );

endmodule

/* testbench/smc_props.sv */
/*
 * Bus assertions bound to the register bank
 */
module smc_props (
  input logic clk,
  input logic rst_n,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i
);

  int fail_count = 0;

  ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    ack_i |=> !ack_i)  // One-clock pulse
    else begin
      fail_count++;
      $error("ack stayed high for two cycles");
    end

  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    ack_i |-> $past(cyc_i && stb_i))
    else begin
      fail_count++;
      $error("ack without a request in the cycle before");
    end

endmodule

bind smc_wb_regs smc_props props_i (
  .clk   (clk),
  .rst_n (rst_n),
  .cyc_i (wbs_cyc_i),
  .stb_i (wbs_stb_i),
  .ack_i (wbs_ack_o)
);

/* testbench/smc_checker.sv */
/*
 * Checker that records coil pattern changes and compares them and
 * the bus read data with expected values
 */
module smc_checker (
  input logic        clk,
  input logic        rst_n,
  input logic        ack_i,
  input logic [31:0] rd_data_i,
  input logic [3:0]  coils_i     // b2 b1 a2 a1
);

  int          mismatches = 0;
  logic [3:0]  seen [$];
  logic [3:0]  last_coils = 4'd0;
  logic        read_pending = 1'b0;
  string       read_name;
  logic [31:0] read_expected;

  task automatic compare(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && coils_i != 4'd0 && coils_i != last_coils) begin
      seen.push_back(coils_i);  // New pattern
    end
    last_coils = coils_i;
    if (ack_i && read_pending) begin
      read_pending = 1'b0;
      compare(read_name, read_expected, rd_data_i);
    end
  end

  task automatic expect_read(input string name, input logic [31:0] exp_v);
    read_name     = name;
    read_expected = exp_v;
    read_pending  = 1'b1;
  endtask

  task automatic clear_seen();
    seen.delete();
  endtask

  function automatic int seen_count();
    return seen.size();
  endfunction

  task automatic check_idle(input string name);
    compare(name, 32'd0, 32'({ack_i, coils_i}));  // Ack and all coils low
  endtask

  task automatic check_sequence(input string name, input logic [31:0] exp_seq, input int len,
                                input logic exact);
    if (exact) begin
      compare({name, "_count"}, 32'(len), 32'(seen.size()));
    end
    for (int i = 0; i < len && i < seen.size(); i++) begin
      compare($sformatf("%s[%0d]", name, i), 32'(exp_seq[i*4 +: 4]), 32'(seen[i]));
    end
  endtask

endmodule

/* testbench/tb_step_motor_controller.sv */
/*
 * Testbench top with clock, reset, Wishbone tasks, register readback,
 * stepping table and timeout
 */
module tb_step_motor_controller;

  import smc_bus_pkg::*;

  localparam int NROWS = 5;

  logic        clk;
  logic        rst_n;
  logic        wbs_cyc;
  logic        wbs_stb;
  logic        wbs_we;
  bus_word_t   wbs_adr;
  bus_word_t   wbs_dat_w;
  logic [3:0]  wbs_sel;
  bus_word_t   wbs_dat_r;
  logic        wbs_ack;
  logic [3:0]  coils;            // b2 b1 a2 a1
  logic [31:0] rng = 32'd58246;
  int          cycles = 0;
  int          limit = 2000;
  int          total;

  // One coil pattern per nibble with the first pattern lowest
  string     row_name   [NROWS] = '{"half_up", "half_down", "full_up", "bipolar", "free_run"};
  bus_word_t row_config [NROWS] = '{32'hA000_00FF, 32'hA000_00FF, 32'h8000_00FF,
                                    32'hE000_00FF, 32'hA000_00FF};
  bus_word_t row_period [NROWS] = '{32'd0, 32'd1, 32'd0, 32'd0, 32'd0};
  bus_word_t row_step   [NROWS] = '{32'h8000_0003, 32'hC000_0003, 32'h8000_0005,
                                    32'h8000_0003, 32'hA000_0000};
  int        row_steps  [NROWS] = '{4, 4, 6, 4, 5};
  bus_word_t row_seq    [NROWS] = '{32'h0006_2319, 32'h0006_4C89, 32'h0000_C639,
                                    32'h0006_4519, 32'h0046_2319};
  int        row_len    [NROWS] = '{5, 5, 4, 5, 6};
  logic      row_stops  [NROWS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0};  // Free run keeps going
  bus_word_t row_div    [NROWS];

  step_motor_controller step_motor_controller_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wbs_cyc_i  (wbs_cyc),
    .wbs_stb_i  (wbs_stb),
    .wbs_adr_i  (wbs_adr),
    .wbs_we_i   (wbs_we),
    .wbs_dat_i  (wbs_dat_w),
    .wbs_sel_i  (wbs_sel),
    .wbs_dat_o  (wbs_dat_r),
    .wbs_ack_o  (wbs_ack),
    .motor_a1_o (coils[0]),
    .motor_a2_o (coils[1]),
    .motor_b1_o (coils[2]),
    .motor_b2_o (coils[3])
  );

  smc_checker checker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ack_i     (wbs_ack),
    .rd_data_i (wbs_dat_r),
    .coils_i   (coils)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] rand32();
    rng = rng ^ (rng << 13);  // xorshift32
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #5;
  endtask

  // One request that returns once ack is seen and stb is dropped
  task automatic bus_cycle(input logic we, input reg_addr_t addr, input bus_word_t data,
                           input logic [3:0] sel);
    wbs_cyc   = 1'b1;
    wbs_stb   = 1'b1;
    wbs_we    = we;
    wbs_adr   = bus_word_t'(addr) << ADDR_LSB;
    wbs_dat_w = data;
    wbs_sel   = sel;
    @(negedge clk);
    while (!wbs_ack) begin
      @(negedge clk);
    end
    idle(1);
    wbs_cyc = 1'b0;
    wbs_stb = 1'b0;
    wbs_we  = 1'b0;
  endtask

  task automatic register_test();
    reg_addr_t   addr [3];
    bus_word_t   valid [3];
    bus_word_t   model [3];
    bus_word_t   data;
    bus_word_t   mask;
    logic [31:0] sel_word;
    int          k;
    addr  = '{CONFIG_ADDR, DIVIDER_ADDR, PERIOD_ADDR};
    valid = '{32'hE000_00FF, 32'hFFFF_FFFF, 32'hFFFF_FFFF};  // Config reserved bits read 0
    model = '{32'd0, 32'd0, 32'd0};
    k     = 0;
    for (int i = 0; i < 12; i++) begin
      k        = int'(rand32() % 3);
      data     = rand32();
      sel_word = rand32();
      mask     = {{8{sel_word[3]}}, {8{sel_word[2]}}, {8{sel_word[1]}}, {8{sel_word[0]}}};
      checker_i.expect_read($sformatf("write_old_reg%0d", addr[k]), model[k]);
      bus_cycle(1'b1, addr[k], data, sel_word[3:0]);
      model[k] = ((model[k] & ~mask) | (data & mask)) & valid[k];
      checker_i.expect_read($sformatf("readback_reg%0d", addr[k]), model[k]);
      bus_cycle(1'b0, addr[k], '0, 4'hF);
    end
    checker_i.expect_read("unused_addr", model[k]);  // dat_o keeps the last read
    bus_cycle(1'b0, 3'd5, '0, 4'hF);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    rst_n     = 1'b0;
    wbs_cyc   = 1'b0;
    wbs_stb   = 1'b0;
    wbs_we    = 1'b0;
    wbs_adr   = '0;
    wbs_dat_w = '0;
    wbs_sel   = '0;
    for (int r = 0; r < NROWS; r++) begin
      row_div[r] = rand32() & 32'd3;
      limit += int'((row_steps[r] + 2) * (row_period[r] + 1) * 256 * (row_div[r] + 1));
    end
    idle(4);
    rst_n = 1'b1;
    idle(1);
    checker_i.check_idle("after_reset");
    register_test();
    for (int r = 0; r < NROWS; r++) begin
      bus_cycle(1'b1, CONFIG_ADDR, '0, 4'hF);  // Disable clears phase and outputs
      idle(2);
      checker_i.check_idle({row_name[r], "_disabled"});
      bus_cycle(1'b1, DIVIDER_ADDR, row_div[r], 4'hF);
      bus_cycle(1'b1, PERIOD_ADDR, row_period[r], 4'hF);
      bus_cycle(1'b1, STEP_ADDR, row_step[r], 4'hF);
      checker_i.clear_seen();
      bus_cycle(1'b1, CONFIG_ADDR, row_config[r], 4'hF);
      while (checker_i.seen_count() < row_len[r]) begin
        idle(1);
      end
      if (row_stops[r]) begin
        // One more step time with no change expected
        idle(int'((row_period[r] + 1) * 256 * (row_div[r] + 1)));
        checker_i.expect_read({row_name[r], "_step_reg"}, row_step[r] & 32'h4000_0000);
        bus_cycle(1'b0, STEP_ADDR, '0, 4'hF);
      end
      checker_i.check_sequence(row_name[r], row_seq[r], row_len[r], row_stops[r]);
    end
    total = checker_i.mismatches + step_motor_controller_i.wb_regs_i.props_i.fail_count;
    $display("Errors: %0d mismatches, %0d assertion failures",
             checker_i.mismatches, step_motor_controller_i.wb_regs_i.props_i.fail_count);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* step_motor_controller.f */
hw/smc_bus_pkg.sv
hw/smc_motor_pkg.sv
hw/smc_wb_regs.sv
hw/tick_prescaler.sv
hw/pwm_generator.sv
hw/motor_sequencer.sv
hw/step_motor_controller.sv
testbench/smc_props.sv
testbench/smc_checker.sv
testbench/tb_step_motor_controller.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_step_motor_controller \
  -f step_motor_controller.f
out=$(./obj_dir/Vtb_step_motor_controller +verilator+error+limit+100 2>&1 || true)
echo "$out"
echo "$out" | grep -qx "Test OK"
